// ==== Bender.yml ====
package:
  name: block_match

sources:
  - sad_pkg.sv
  - search_pkg.sv
  - sad_pe.sv
  - min_select.sv
  - best_match_tracker.sv
  - block_match_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - block_match_tb.sv

// ==== best_match_tracker.sv ====
`timescale 1ns/100ps

// lines up enable and row with the selector output and keeps the best match.
module best_match_tracker
	import sad_pkg::*;
	import search_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic enable,
	input row_t row,
	input sad_t min_sad,
	input col_t min_col,
	output sad_t best_sad,
	output position_t best_pos
);

	// bit 0 holds the newest sample.
	logic [align_depth-1:0] enable_dly;
	row_t [align_depth-1:0] row_dly;

	logic enable_aligned;
	row_t row_aligned;

	assign enable_aligned = enable_dly[align_depth-1];
	assign row_aligned = row_dly[align_depth-1];

	// ~~~~~~~~~~~~~~~~~~~~
	// delay line
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (rst_n)
		begin
			enable_dly <= '0;
			row_dly <= '0;
		end
		else
		begin
			enable_dly <= {enable_dly[align_depth-2:0], enable};
			row_dly <= {row_dly[align_depth-2:0], row};
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// running best
	// ~~~~~~~~~~~~~~~~~~~~

	// the stored match survives only if strictly smaller, so a tie moves the
	// position to the later row. an idle cycle drops back to the worst match.
	always_ff @(posedge clk)
	begin
		if (rst_n)
		begin
			best_sad <= sad_worst;
			best_pos <= '0;
		end
		else if (!enable_aligned)
		begin
			best_sad <= sad_worst;
			best_pos <= '0;
		end
		else if (min_sad <= best_sad)
		begin
			best_sad <= min_sad;
			best_pos <= '{row: row_aligned, col: min_col};
		end
	end

endmodule

// ==== block_match_tb.sv ====
`timescale 1ns/100ps

module block_match_tb
	import sad_pkg::*;
	import search_pkg::*;
();

	// ~~~~~~~~~~~~~~~~~~~~
	// stimulus table
	// ~~~~~~~~~~~~~~~~~~~~

	localparam logic [2:0] kind_random = 3'd0;
	localparam logic [2:0] kind_forced = 3'd1;
	localparam logic [2:0] kind_equal = 3'd2;
	localparam logic [2:0] kind_idle = 3'd3;

	localparam int entry_count = 8;
	localparam int test_count = entry_count + 1;
	localparam int slot_count = 64;
	localparam int out_delay = 5;
	localparam int reset_limit = 20;
	localparam sad_t worst_sad = 12'hfff;

	typedef struct packed {
		logic [2:0] kind;
		logic [4:0] len;
		row_t row_start;
		row_t force_row;
		col_t force_col;
		pixel_t cur_val;
		pixel_t cand_val;
		logic fixed;
		sad_t exp_sad;
		position_t exp_pos;
	} entry_t;

	entry_t table_q [entry_count];

	logic clk;
	logic rst_n;
	logic enable;
	row_t row;
	block_t cur_block;
	cand_array_t cand_blocks;
	sad_t best_sad;
	position_t best_pos;

	// expected outputs, indexed by the falling edge on which they are checked.
	sad_t exp_sad_q [slot_count];
	position_t exp_pos_q [slot_count];
	int test_q [slot_count];
	bit last_q [slot_count];

	int test_errs [test_count];
	int error_count;
	int check_count;
	int tests_passed;
	int tests_failed;
	bit timed_out;
	logic [15:0] lfsr_state;
	sad_t model_sad;
	position_t model_pos;

	tb_clock_gen u_tb_clock_gen (
		.clk(clk),
		.rst_n(rst_n)
	);

	block_match_top u_block_match_top (
		.clk(clk),
		.rst_n(rst_n),
		.enable(enable),
		.row(row),
		.cur_block(cur_block),
		.cand_blocks(cand_blocks),
		.best_sad(best_sad),
		.best_pos(best_pos)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~

	// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic pixel_t random_pixel();
		pixel_t p;
		p = '0;
		for (int b = 0; b < 8; b++)
			p = {p[6:0], lfsr_bit()};
		return p;
	endfunction

	function automatic sad_t block_sad(input block_t a, input block_t b);
		int sum;
		int d;
		sum = 0;
		for (int y = 0; y < 4; y++)
		begin
			for (int x = 0; x < 4; x++)
			begin
				d = int'(a[y][x]) - int'(b[y][x]);
				if (d < 0)
					d = -d;
				sum = sum + d;
			end
		end
		return sad_t'(sum);
	endfunction

	function automatic entry_t make_entry(input logic [2:0] kind, input int len,
		input row_t row_start, input row_t force_row, input col_t force_col,
		input pixel_t cur_val, input pixel_t cand_val, input logic fixed,
		input sad_t exp_sad, input row_t exp_row, input col_t exp_col);
		entry_t e;
		e.kind = kind;
		e.len = len[4:0];
		e.row_start = row_start;
		e.force_row = force_row;
		e.force_col = force_col;
		e.cur_val = cur_val;
		e.cand_val = cand_val;
		e.fixed = fixed;
		e.exp_sad = exp_sad;
		e.exp_pos.row = exp_row;
		e.exp_pos.col = exp_col;
		return e;
	endfunction

	function automatic string entry_name(input int t);
		case (t)
			0: return "reset values";
			1: return "single row";
			2: return "idle after single row";
			3: return "best over sixteen rows";
			4: return "clear when idle";
			5: return "tie rules";
			6: return "idle before largest SAD";
			7: return "largest SAD";
			default: return "final idle";
		endcase
	endfunction

	task automatic check_sad(input string sig, input sad_t got, input sad_t exp,
		input int t, input int cyc);
		check_count++;
		if (got !== exp)
		begin
			$display("ERR %s got 0x%h expected 0x%h (test %0d, cycle %0d)",
				sig, got, exp, t, cyc);
			test_errs[t]++;
			error_count++;
		end
	endtask

	task automatic check_pos(input string sig, input position_t got, input position_t exp,
		input int t, input int cyc);
		check_count++;
		if (got !== exp)
		begin
			$display("ERR %s got 0x%h expected 0x%h (test %0d, cycle %0d)",
				sig, got, exp, t, cyc);
			test_errs[t]++;
			error_count++;
		end
	endtask

	task automatic report_test(input int t);
		if (test_errs[t] == 0)
		begin
			tests_passed++;
			$display("test %0d %s: ok", t, entry_name(t));
		end
		else
		begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", t, entry_name(t), test_errs[t]);
		end
	endtask

	task automatic verify_cycle(input int n);
		check_sad("best_sad", best_sad, exp_sad_q[n], test_q[n], n);
		check_pos("best_pos", best_pos, exp_pos_q[n], test_q[n], n);
		if (last_q[n])
			report_test(test_q[n]);
	endtask

	// drives one row of an entry and records what the outputs must show later.
	task automatic apply_row(input entry_t e, input int j, input int t, input int slot);
		row_t r;
		sad_t s;
		sad_t row_min;
		col_t row_col;
		r = e.row_start + row_t'(j);
		if (e.kind == kind_idle)
		begin
			enable = 1'b0;
			row = '0;
			cur_block = '0;
			cand_blocks = '0;
			model_sad = worst_sad;
			model_pos = '0;
		end
		else
		begin
			enable = 1'b1;
			row = r;
			for (int y = 0; y < 4; y++)
			begin
				for (int x = 0; x < 4; x++)
				begin
					if (e.kind == kind_equal)
						cur_block[y][x] = e.cur_val;
					else
						cur_block[y][x] = random_pixel();
				end
			end
			for (int i = 0; i < 16; i++)
			begin
				for (int y = 0; y < 4; y++)
				begin
					for (int x = 0; x < 4; x++)
					begin
						if (e.kind == kind_equal)
							cand_blocks[i][y][x] = e.cand_val;
						else
							cand_blocks[i][y][x] = random_pixel();
					end
				end
			end
			if (e.kind == kind_forced && r == e.force_row)
				cand_blocks[e.force_col] = cur_block;

			// lowest column wins among equal sums within the row.
			row_min = block_sad(cur_block, cand_blocks[0]);
			row_col = '0;
			for (int i = 1; i < 16; i++)
			begin
				s = block_sad(cur_block, cand_blocks[i]);
				if (s < row_min)
				begin
					row_min = s;
					row_col = col_t'(i);
				end
			end

			// the stored match survives only when strictly smaller.
			if (!(model_sad < row_min))
			begin
				model_sad = row_min;
				model_pos.row = r;
				model_pos.col = row_col;
			end
		end
		exp_sad_q[slot] = model_sad;
		exp_pos_q[slot] = model_pos;
		test_q[slot] = t;
		last_q[slot] = (j == int'(e.len) - 1);
		if (last_q[slot] && e.fixed)
		begin
			exp_sad_q[slot] = e.exp_sad;
			exp_pos_q[slot] = e.exp_pos;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		int n;
		int guard;
		int hist_count;
		enable = 1'b0;
		row = '0;
		cur_block = '0;
		cand_blocks = '0;
		lfsr_state = 16'd93;
		model_sad = worst_sad;
		model_pos = '0;
		error_count = 0;
		check_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		for (int t = 0; t < test_count; t++)
			test_errs[t] = 0;

		table_q[0] = make_entry(kind_random, 1, 4'd5, 4'd0, 4'd0, 8'h00, 8'h00,
			1'b0, 12'h000, 4'd0, 4'd0);
		table_q[1] = make_entry(kind_idle, 1, 4'd0, 4'd0, 4'd0, 8'h00, 8'h00,
			1'b1, 12'hfff, 4'd0, 4'd0);
		table_q[2] = make_entry(kind_forced, 16, 4'd0, 4'd9, 4'd6, 8'h00, 8'h00,
			1'b1, 12'h000, 4'd9, 4'd6);
		table_q[3] = make_entry(kind_idle, 1, 4'd0, 4'd0, 4'd0, 8'h00, 8'h00,
			1'b1, 12'hfff, 4'd0, 4'd0);
		table_q[4] = make_entry(kind_equal, 2, 4'd3, 4'd0, 4'd0, 8'h10, 8'h13,
			1'b1, 12'h030, 4'd4, 4'd0);
		table_q[5] = make_entry(kind_idle, 1, 4'd0, 4'd0, 4'd0, 8'h00, 8'h00,
			1'b1, 12'hfff, 4'd0, 4'd0);
		table_q[6] = make_entry(kind_equal, 1, 4'd7, 4'd0, 4'd0, 8'h00, 8'hff,
			1'b1, 12'hff0, 4'd7, 4'd0);
		table_q[7] = make_entry(kind_idle, 2, 4'd0, 4'd0, 4'd0, 8'h00, 8'h00,
			1'b1, 12'hfff, 4'd0, 4'd0);

		// the first slots cover the pipeline right after reset.
		for (int k = 0; k < out_delay; k++)
		begin
			exp_sad_q[k] = worst_sad;
			exp_pos_q[k] = '0;
			test_q[k] = 0;
			last_q[k] = (k == out_delay - 1);
		end

		guard = 0;
		@(negedge clk);
		while (rst_n && guard < reset_limit)
		begin
			check_sad("best_sad", best_sad, worst_sad, 0, guard);
			check_pos("best_pos", best_pos, '0, 0, guard);
			@(negedge clk);
			guard++;
		end
		if (rst_n)
		begin
			timed_out = 1'b1;
			$display("timeout: reset was still asserted after %0d cycles", reset_limit);
		end

		n = 0;
		hist_count = out_delay;
		if (!timed_out)
		begin
			for (int e = 0; e < entry_count; e++)
			begin
				for (int j = 0; j < int'(table_q[e].len); j++)
				begin
					verify_cycle(n);
					apply_row(table_q[e], j, e + 1, n + out_delay);
					hist_count = n + out_delay + 1;
					@(negedge clk);
					n++;
				end
			end

			// the last rows still sit in the pipeline.
			while (n < hist_count)
			begin
				verify_cycle(n);
				enable = 1'b0;
				row = '0;
				@(negedge clk);
				n++;
			end
		end

		$display("tests %0d passed %0d failed %0d, checks %0d, errors %0d",
			tests_passed + tests_failed, tests_passed, tests_failed, check_count, error_count);
		if (error_count == 0 && !timed_out)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== block_match_top.sv ====
`timescale 1ns/100ps

// full-search block matching over one search-window row per cycle.
module block_match_top
	import sad_pkg::*;
	import search_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic enable,
	input row_t row,
	input block_t cur_block,
	input cand_array_t cand_blocks,
	output sad_t best_sad,
	output position_t best_pos
);

	sad_array_t sads;
	sad_t min_sad;
	col_t min_col;

	// ~~~~~~~~~~~~~~~~~~~~
	// processing elements
	// ~~~~~~~~~~~~~~~~~~~~

	// every PE sees the same current block against its own column offset.
	for (genvar i = 0; i < pe_count; i++)
	begin : g_pe
		sad_pe u_sad_pe (
			.clk(clk),
			.rst_n(rst_n),
			.cur_block(cur_block),
			.cand_block(cand_blocks[i]),
			.sad(sads[i])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// selection and tracking
	// ~~~~~~~~~~~~~~~~~~~~

	min_select u_min_select (
		.clk(clk),
		.rst_n(rst_n),
		.sads(sads),
		.min_sad(min_sad),
		.min_col(min_col)
	);

	best_match_tracker u_best_match_tracker (
		.clk(clk),
		.rst_n(rst_n),
		.enable(enable),
		.row(row),
		.min_sad(min_sad),
		.min_col(min_col),
		.best_sad(best_sad),
		.best_pos(best_pos)
	);

endmodule

// ==== compile.f ====
sad_pkg.sv
search_pkg.sv
sad_pe.sv
min_select.sv
best_match_tracker.sv
block_match_top.sv
tb_clock_gen.sv
block_match_tb.sv

// ==== min_select.sv ====
`timescale 1ns/100ps

// sixteen-way minimum of the PE sums, returning the value and its column.
module min_select
	import sad_pkg::*;
	import search_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input sad_array_t sads,
	output sad_t min_sad,
	output col_t min_col
);

	// winners of each group of four, before and after the stage one register.
	sad_t [pe_count/group_size-1:0] grp_sad_next;
	col_t [pe_count/group_size-1:0] grp_col_next;
	sad_t [pe_count/group_size-1:0] grp_sad;
	col_t [pe_count/group_size-1:0] grp_col;

	sad_t sel_sad;
	col_t sel_col;

	// ~~~~~~~~~~~~~~~~~~~~
	// stage one
	// ~~~~~~~~~~~~~~~~~~~~

	// a later column only replaces the current pick when strictly smaller,
	// so the lowest column wins among equal sums.
	always_comb
	begin
		for (int g = 0; g < pe_count/group_size; g++)
		begin
			grp_sad_next[g] = sads[g*group_size];
			grp_col_next[g] = col_t'(g*group_size);
			for (int k = 1; k < group_size; k++)
			begin
				if (sads[g*group_size+k] < grp_sad_next[g])
				begin
					grp_sad_next[g] = sads[g*group_size+k];
					grp_col_next[g] = col_t'(g*group_size+k);
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_n)
		begin
			grp_sad <= '0;
			grp_col <= '0;
		end
		else
		begin
			grp_sad <= grp_sad_next;
			grp_col <= grp_col_next;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// stage two
	// ~~~~~~~~~~~~~~~~~~~~

	// groups are scanned from low columns upward with the same strict compare.
	always_comb
	begin
		sel_sad = grp_sad[0];
		sel_col = grp_col[0];
		for (int g = 1; g < pe_count/group_size; g++)
		begin
			if (grp_sad[g] < sel_sad)
			begin
				sel_sad = grp_sad[g];
				sel_col = grp_col[g];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_n)
		begin
			min_sad <= '0;
			min_col <= '0;
		end
		else
		begin
			min_sad <= sel_sad;
			min_col <= sel_col;
		end
	end

endmodule

// ==== sad_pe.sv ====
`timescale 1ns/100ps

// sum of absolute differences between the current block and one candidate.
module sad_pe
	import sad_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input block_t cur_block,
	input block_t cand_block,
	output sad_t sad
);

	// sixteen absolute differences, index is row * block_dim + column.
	pixel_t [block_dim*block_dim-1:0] abs_diff;

	// adder tree levels, each one bit wider than the last.
	logic [pixel_w:0] sum_l1 [block_dim*block_dim/2];
	logic [pixel_w+1:0] sum_l2 [block_dim*block_dim/4];
	logic [pixel_w+2:0] sum_l3 [block_dim*block_dim/8];

	// ~~~~~~~~~~~~~~~~~~~~
	// stage one
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (rst_n)
		begin
			abs_diff <= '0;
		end
		else
		begin
			for (int r = 0; r < block_dim; r++)
			begin
				for (int c = 0; c < block_dim; c++)
				begin
					if (cur_block[r][c] > cand_block[r][c])
						abs_diff[r*block_dim+c] <= cur_block[r][c] - cand_block[r][c];
					else
						abs_diff[r*block_dim+c] <= cand_block[r][c] - cur_block[r][c];
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// stage two
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		for (int i = 0; i < block_dim*block_dim/2; i++)
			sum_l1[i] = abs_diff[2*i] + abs_diff[2*i+1];
		for (int i = 0; i < block_dim*block_dim/4; i++)
			sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
		for (int i = 0; i < block_dim*block_dim/8; i++)
			sum_l3[i] = sum_l2[2*i] + sum_l2[2*i+1];
	end

	// the final add carries into bit 11, so 0xff0 is reachable without overflow.
	always_ff @(posedge clk)
	begin
		if (rst_n)
		begin
			sad <= '0;
		end
		else
		begin
			sad <= sum_l3[0] + sum_l3[1];
		end
	end

endmodule

// ==== sad_pkg.sv ====
// pixel and SAD types shared by the processing elements and the selector.
package sad_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// array dimensions
	// ~~~~~~~~~~~~~~~~~~~~

	localparam int pixel_w = 8;
	localparam int block_dim = 4;

	// one PE per column offset of the search window.
	localparam int pe_count = 16;

	// sixteen pixels of at most 255 each sum to at most 4080.
	localparam int sad_w = 12;

	// ~~~~~~~~~~~~~~~~~~~~
	// types
	// ~~~~~~~~~~~~~~~~~~~~

	typedef logic [pixel_w-1:0] pixel_t;

	// indexed as [row][column].
	typedef pixel_t [block_dim-1:0][block_dim-1:0] block_t;

	// candidate i is the block at column offset i.
	typedef block_t [pe_count-1:0] cand_array_t;

	typedef logic [sad_w-1:0] sad_t;

	typedef sad_t [pe_count-1:0] sad_array_t;

endpackage

// ==== search_pkg.sv ====
// search-window positions, the worst-match value and pipeline latencies.
package search_pkg;

	import sad_pkg::sad_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// position types
	// ~~~~~~~~~~~~~~~~~~~~

	typedef logic [3:0] row_t;

	// the column offset is the PE index.
	typedef logic [3:0] col_t;

	typedef struct packed {
		row_t row;
		col_t col;
	} position_t;

	// the running minimum starts from the largest SAD code.
	localparam sad_t sad_worst = '1;

	// the selector finds a minimum within each group of this many SADs first.
	localparam int group_size = 4;

	// ~~~~~~~~~~~~~~~~~~~~
	// pipeline latencies
	// ~~~~~~~~~~~~~~~~~~~~

	localparam int pe_latency = 2;
	localparam int select_latency = 2;

	// enable and row are delayed by this much to meet the selector output.
	localparam int align_depth = pe_latency + select_latency;

endpackage

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

// clock and reset for the block matching testbench.
module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	localparam int half_period = 20;
	localparam int reset_cycles = 5;

	initial
	begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// reset is released on a falling edge so it never races the sampling edge.
	initial
	begin
		rst_n = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst_n <= 1'b0;
	end

endmodule
